// File: verilog.f
+incdir+.
hbus_pkg.sv
hbus_shift_if.sv
hbus_sync_fifo.sv
hbus_beat_counter.sv
hbus_beat_shifter.sv
hbus_fsm.sv
hbus_fifo.sv
hbus_fifo_chk.sv
tb_hbus_fifo.sv

// File: run.sh
#!/bin/sh
# Build and run the HyperBus bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_hbus_fifo \
  -f verilog.f -o tb_hbus_fifo \
  && ./obj_dir/tb_hbus_fifo > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
# Failure is decided from the testbench log
grep -q "TB FAILED" sim.log && { echo "simulation reported a failure"; exit 1; }
echo "simulation finished without failure"
exit 0

// File: tb_hbus_fifo.sv
`include "hbus_config.svh"

module tb_hbus_fifo;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int TMO = 2000;

  logic                    clk;
  logic                    hbus_rst;
  logic                    rrq_i;
  logic                    wrq_i;
  logic [`HBUS_ADDR_W-1:0] adr_i;
  logic [`HBUS_WORD_W-1:0] tx_dat_i;
  logic [`HBUS_WORD_W-1:0] rx_dat_o;
  logic                    rx_valid_o;
  logic                    busy_o;
  logic [`HBUS_ADDR_W-1:0] hbus_adr_o;
  logic [`HBUS_DATA_W-1:0] hbus_dat_i;
  logic [`HBUS_DATA_W-1:0] hbus_dat_o;
  logic                    hbus_rrq_o;
  logic                    hbus_wrq_o;
  logic                    hbus_ready_i;
  logic                    hbus_valid_i;
  logic                    hbus_busy_i;

  integer seed = 84;
  int     mismatch_errs = 0;
  int     other_errs = 0;
  bit     aborted = 1'b0;

  // Memory slave state
  logic [`HBUS_DATA_W-1:0] slave_mem [logic [`HBUS_ADDR_W-1:0]];
  logic                    hold_busy = 1'b0;
  logic                    rd_seen = 1'b0;
  logic [`HBUS_ADDR_W-1:0] rd_adr;
  int                      wr_k = 0;
  int                      rd_k = 0;

  // Reference model, commands kept in issue order
  logic [`HBUS_WORD_W-1:0] ref_mem [logic [`HBUS_ADDR_W-1:0]];
  logic                    cmd_wr_q [$];
  logic [`HBUS_ADDR_W-1:0] cmd_adr_q [$];
  logic [`HBUS_WORD_W-1:0] cmd_dat_q [$];
  logic [`HBUS_WORD_W-1:0] exp_rd_q [$];

  hbus_fifo u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Contents of never written memory, derived from the whole address
  function automatic logic [`HBUS_DATA_W-1:0] fill_beat(input logic [`HBUS_ADDR_W-1:0] a);
    return a[15:0] ^ a[31:16] ^ 16'h5a3c;
  endfunction

  function automatic logic [`HBUS_DATA_W-1:0] slave_read(input logic [`HBUS_ADDR_W-1:0] a);
    if (slave_mem.exists(a)) begin
      return slave_mem[a];
    end
    return fill_beat(a);
  endfunction

  // Beat k of a word lives at address plus k, low half first
  function automatic logic [`HBUS_WORD_W-1:0] ref_word(input logic [`HBUS_ADDR_W-1:0] a);
    logic [`HBUS_WORD_W-1:0] w;
    if (ref_mem.exists(a)) begin
      return ref_mem[a];
    end
    for (int k = 0; k < `HBUS_BEATS; k++) begin
      w[k*`HBUS_DATA_W +: `HBUS_DATA_W] = fill_beat(a + `HBUS_ADDR_W'(k));
    end
    return w;
  endfunction

  // Even word addresses in a small window so reads hit earlier writes
  function automatic logic [`HBUS_ADDR_W-1:0] rand_addr(input logic [31:0] r);
    return {24'h100000, 2'b00, r[8:4], 1'b0};
  endfunction

  task automatic end_run();
    $display("errors: %0d mismatches, %0d other, %0d assertion", mismatch_errs, other_errs,
             u_dut.u_chk.fail_cnt);
    if (mismatch_errs == 0 && other_errs == 0 && u_dut.u_chk.fail_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h, expected %h", name, got, exp);
      mismatch_errs++;
    end
  endtask

  task automatic retire_cmd();
    if (cmd_wr_q.size() != 0) begin
      void'(cmd_wr_q.pop_front());
      void'(cmd_adr_q.pop_front());
      void'(cmd_dat_q.pop_front());
    end
  endtask

  task automatic take_write_beat();
    logic [`HBUS_ADDR_W-1:0] a;
    a = hbus_adr_o + `HBUS_ADDR_W'(wr_k);
    if (cmd_wr_q.size() == 0 || !cmd_wr_q[0]) begin
      $display("write beat on the bus with no write command queued");
      other_errs++;
    end else begin
      check_val("hbus_adr_o", hbus_adr_o, cmd_adr_q[0]);
      check_val("hbus_dat_o", 32'(hbus_dat_o),
                32'(cmd_dat_q[0][wr_k*`HBUS_DATA_W +: `HBUS_DATA_W]));
    end
    slave_mem[a] = hbus_dat_o;
    wr_k++;
    if (wr_k == `HBUS_BEATS) begin
      wr_k = 0;
      retire_cmd();
    end
  endtask

  task automatic take_read_beat();
    if (rd_k == 0) begin
      if (cmd_wr_q.size() == 0 || cmd_wr_q[0]) begin
        $display("read request on the bus with no read command queued");
        other_errs++;
      end else begin
        check_val("hbus_adr_o", hbus_adr_o, cmd_adr_q[0]);
      end
    end
    rd_k++;
    if (rd_k == `HBUS_BEATS) begin
      retire_cmd();
    end
  endtask

  task automatic check_rx();
    logic [`HBUS_WORD_W-1:0] exp;
    if (exp_rd_q.size() == 0) begin
      $display("rx_valid_o pulsed with no read outstanding");
      other_errs++;
    end else begin
      exp = exp_rd_q.pop_front();
      check_val("rx_dat_o", rx_dat_o, exp);
    end
  endtask

  // Bus and user outputs are observed at the falling edge, between updates
  always @(negedge clk) begin
    if (!hbus_rst) begin
      if (hbus_wrq_o && hbus_ready_i) begin
        take_write_beat();
      end
      if (!hbus_rrq_o) begin
        rd_k = 0;
      end else if (hbus_valid_i && rd_k < `HBUS_BEATS) begin
        take_read_beat();
      end
      rd_seen = hbus_rrq_o;
      rd_adr  = hbus_adr_o;
      if (rx_valid_o) begin
        check_rx();
      end
    end
  end

  // Slave drives its stalls and read beats on the rising edge
  always @(posedge clk) begin
    hbus_ready_i <= ($random(seed) & 3) != 0;
    hbus_busy_i  <= hold_busy || (($random(seed) & 15) == 0);
    if (rd_seen && rd_k < `HBUS_BEATS && (($random(seed) & 3) != 0)) begin
      hbus_valid_i <= 1'b1;
      hbus_dat_i   <= slave_read(rd_adr + `HBUS_ADDR_W'(rd_k));
    end else begin
      hbus_valid_i <= 1'b0;
    end
  end

  // Raise one strobe and record the command in the reference model
  task automatic drive_strobe(input logic is_wr, input logic [`HBUS_ADDR_W-1:0] addr,
                              input logic [`HBUS_WORD_W-1:0] data);
    rrq_i    <= !is_wr;
    wrq_i    <= is_wr;
    adr_i    <= addr;
    tx_dat_i <= data;
    cmd_wr_q.push_back(is_wr);
    cmd_adr_q.push_back(addr);
    cmd_dat_q.push_back(data);
    if (is_wr) begin
      ref_mem[addr] = data;
    end else begin
      exp_rd_q.push_back(ref_word(addr));
    end
  endtask

  task automatic strobe(input logic is_wr, input logic [`HBUS_ADDR_W-1:0] addr,
                        input logic [`HBUS_WORD_W-1:0] data);
    int t;
    t = 0;
    @(negedge clk);
    while (busy_o && t < TMO && !aborted) begin
      @(negedge clk);
      t++;
    end
    if (!aborted && busy_o) begin
      $display("timeout: busy_o stayed high while a strobe was waiting");
      other_errs++;
      aborted = 1'b1;
    end
    if (!aborted) begin
      @(posedge clk);
      drive_strobe(is_wr, addr, data);
      @(posedge clk);
      rrq_i <= 1'b0;
      wrq_i <= 1'b0;
    end
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    while ((cmd_wr_q.size() != 0 || exp_rd_q.size() != 0) && t < TMO && !aborted) begin
      @(negedge clk);
      t++;
    end
    if (!aborted && (cmd_wr_q.size() != 0 || exp_rd_q.size() != 0)) begin
      $display("timeout: %0d commands and %0d read words still outstanding",
               cmd_wr_q.size(), exp_rd_q.size());
      other_errs++;
      aborted = 1'b1;
    end
  endtask

  // Memory held busy while strobes on consecutive cycles fill the queues
  task automatic fill_queues(input logic is_wr);
    logic [31:0] r;
    @(negedge clk);
    hold_busy = 1'b1;
    @(negedge clk);
    for (int i = 0; i < `HBUS_QDEPTH; i++) begin
      r = $random(seed);
      @(posedge clk);
      drive_strobe(is_wr, rand_addr(r), $random(seed));
      @(negedge clk);
      if (busy_o) begin
        $display("busy_o went high before the queues were full");
        other_errs++;
      end
    end
    @(posedge clk);
    rrq_i <= 1'b0;
    wrq_i <= 1'b0;
    @(negedge clk);
    if (!busy_o) begin
      $display("busy_o stayed low with a full queue");
      other_errs++;
    end
    hold_busy = 1'b0;
    wait_drain();
  endtask

  initial begin
    logic [31:0] r;
    hbus_rst     = 1'b1;
    rrq_i        = 1'b0;
    wrq_i        = 1'b0;
    adr_i        = '0;
    tx_dat_i     = '0;
    hbus_dat_i   = '0;
    hbus_ready_i = 1'b0;
    hbus_valid_i = 1'b0;
    hbus_busy_i  = 1'b0;
    repeat (4) @(posedge clk);
    hbus_rst <= 1'b0;

    @(negedge clk);
    check_val("hbus_rrq_o", 32'(hbus_rrq_o), 32'h0);
    check_val("hbus_wrq_o", 32'(hbus_wrq_o), 32'h0);
    check_val("rx_valid_o", 32'(rx_valid_o), 32'h0);
    check_val("busy_o", 32'(busy_o), 32'h0);

    // Write then read back one word
    strobe(1'b1, 32'h1000_0100, 32'hcafe_1234);
    strobe(1'b0, 32'h1000_0100, '0);
    wait_drain();

    // Random traffic
    for (int n = 0; n < 200 && !aborted; n++) begin
      r = $random(seed);
      strobe(r[0], rand_addr(r), $random(seed));
      repeat (r[11:10]) @(posedge clk);
    end
    wait_drain();

    // Commands wait while the memory reports busy
    if (!aborted) begin
      @(negedge clk);
      hold_busy = 1'b1;
      @(negedge clk);
      strobe(1'b1, 32'h1000_0200, 32'h0bad_f00d);
      strobe(1'b0, 32'h1000_0200, '0);
      strobe(1'b0, 32'h1000_0010, '0);
      repeat (20) begin
        @(negedge clk);
        if (hbus_rrq_o || hbus_wrq_o) begin
          $display("a request started while hbus_busy_i was high");
          other_errs++;
        end
      end
      hold_busy = 1'b0;
      wait_drain();
    end

    if (!aborted) begin
      fill_queues(1'b1);
    end
    if (!aborted) begin
      fill_queues(1'b0);
    end
    end_run();
  end

endmodule

// File: hbus_fifo_chk.sv
`include "hbus_config.svh"

module hbus_fifo_chk (
  input logic                    clk,
  input logic                    hbus_rst,
  input logic                    rrq_i,
  input logic                    wrq_i,
  input logic [`HBUS_ADDR_W-1:0] adr_i,
  input logic                    busy_i,
  input logic                    rx_valid_i
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_cnt = 0;

  // One direction on the bus at a time
  a_one_req: assert property (@(posedge clk) disable iff (hbus_rst) !(rrq_i && wrq_i))
    else begin
      fail_cnt++;
      $error("read and write requests high together");
    end

  a_adr_stable: assert property (@(posedge clk) disable iff (hbus_rst)
    ((rrq_i || wrq_i) && $past(rrq_i || wrq_i)) |-> $stable(adr_i))
    else begin
      fail_cnt++;
      $error("hbus_adr_o changed during a request");
    end

  // Start of a transfer needs a free memory on the edge before
  a_no_start_busy: assert property (@(posedge clk) disable iff (hbus_rst)
    $rose(rrq_i || wrq_i) |-> !$past(busy_i))
    else begin
      fail_cnt++;
      $error("request rose while hbus_busy_i was high");
    end

  a_rx_pulse: assert property (@(posedge clk) disable iff (hbus_rst) rx_valid_i |=> !rx_valid_i)
    else begin
      fail_cnt++;
      $error("rx_valid_o high for two cycles in a row");
    end

endmodule

bind hbus_fifo hbus_fifo_chk u_chk (
  .clk(clk),
  .hbus_rst(hbus_rst),
  .rrq_i(hbus_rrq_o),
  .wrq_i(hbus_wrq_o),
  .adr_i(hbus_adr_o),
  .busy_i(hbus_busy_i),
  .rx_valid_i(rx_valid_o)
);

// File: hbus_fifo.sv
`include "hbus_config.svh"

module hbus_fifo (
  input  logic                    clk,
  input  logic                    hbus_rst,
  // User side
  input  logic                    rrq_i,
  input  logic                    wrq_i,
  input  logic [`HBUS_ADDR_W-1:0] adr_i,
  input  logic [`HBUS_WORD_W-1:0] tx_dat_i,
  output logic [`HBUS_WORD_W-1:0] rx_dat_o,
  output logic                    rx_valid_o,
  output logic                    busy_o,
  // HyperBus native memory side
  output logic [`HBUS_ADDR_W-1:0] hbus_adr_o,
  input  logic [`HBUS_DATA_W-1:0] hbus_dat_i,
  output logic [`HBUS_DATA_W-1:0] hbus_dat_o,
  output logic                    hbus_rrq_o,
  output logic                    hbus_wrq_o,
  input  logic                    hbus_ready_i,
  input  logic                    hbus_valid_i,
  input  logic                    hbus_busy_i
);
  import hbus_pkg::*;

  hbus_cmd_t               cmd_wdata;
  hbus_cmd_t               cmd_rdata;
  logic                    cmd_push;
  logic                    cmd_pop;
  logic                    cmd_full;
  logic                    cmd_empty;
  logic                    tx_push;
  logic                    tx_pop;
  logic                    tx_full;
  logic [`HBUS_WORD_W-1:0] tx_rdata;
  logic                    rx_push;
  logic                    rx_pop;
  logic                    rx_empty;
  logic [`HBUS_WORD_W-1:0] rx_rdata;
  logic                    cnt_load;
  logic                    cnt_dec;
  logic                    cnt_last;

  hbus_shift_if shift_bus ();

  // Read strobe wins when both are high
  assign cmd_push           = rrq_i || wrq_i;
  assign tx_push            = wrq_i && !rrq_i;
  assign cmd_wdata.is_write = !rrq_i;
  assign cmd_wdata.addr     = adr_i;

  assign busy_o     = cmd_full || tx_full;
  assign hbus_dat_o = shift_bus.tx_beat;

  hbus_sync_fifo #(.WIDTH($bits(hbus_cmd_t)), .DEPTH(`HBUS_QDEPTH)) u_cmd_q (
    .clk(clk), .hbus_rst(hbus_rst), .push_i(cmd_push), .pop_i(cmd_pop),
    .wdata_i(cmd_wdata), .rdata_o(cmd_rdata), .full_o(cmd_full), .empty_o(cmd_empty)
  );

  hbus_sync_fifo #(.WIDTH(`HBUS_WORD_W), .DEPTH(`HBUS_QDEPTH)) u_tx_q (
    .clk(clk), .hbus_rst(hbus_rst), .push_i(tx_push), .pop_i(tx_pop),
    .wdata_i(tx_dat_i), .rdata_o(tx_rdata), .full_o(tx_full), .empty_o()
  );

  hbus_sync_fifo #(.WIDTH(`HBUS_WORD_W), .DEPTH(`HBUS_QDEPTH)) u_rx_q (
    .clk(clk), .hbus_rst(hbus_rst), .push_i(rx_push), .pop_i(rx_pop),
    .wdata_i(shift_bus.rx_word.word), .rdata_o(rx_rdata), .full_o(), .empty_o(rx_empty)
  );

  hbus_beat_counter u_cnt (
    .clk(clk), .hbus_rst(hbus_rst), .load_i(cnt_load), .dec_i(cnt_dec), .last_o(cnt_last)
  );

  hbus_beat_shifter u_shift (
    .clk(clk), .hbus_rst(hbus_rst), .shift(shift_bus.shifter),
    .tx_word_i(tx_rdata), .hbus_dat_i(hbus_dat_i)
  );

  hbus_fsm u_fsm (
    .clk(clk), .hbus_rst(hbus_rst), .cmd_i(cmd_rdata), .cmd_empty_i(cmd_empty),
    .hbus_ready_i(hbus_ready_i), .hbus_valid_i(hbus_valid_i), .hbus_busy_i(hbus_busy_i),
    .last_i(cnt_last), .cmd_pop_o(cmd_pop), .tx_pop_o(tx_pop), .rx_push_o(rx_push),
    .cnt_load_o(cnt_load), .cnt_dec_o(cnt_dec), .hbus_adr_o(hbus_adr_o),
    .hbus_rrq_o(hbus_rrq_o), .hbus_wrq_o(hbus_wrq_o), .shift(shift_bus.fsm)
  );

  // One word per valid pulse, never two cycles in a row
  assign rx_pop = !rx_empty && !rx_valid_o;

  always_ff @(posedge clk or posedge hbus_rst) begin
    if (hbus_rst) begin
      rx_valid_o <= 1'b0;
    end else begin
      rx_valid_o <= rx_pop;
    end
  end

  always_ff @(posedge clk) begin
    if (rx_pop) begin
      rx_dat_o <= rx_rdata;
    end
  end

endmodule

// File: hbus_fsm.sv
`include "hbus_config.svh"

module hbus_fsm (
  input  logic                    clk,
  input  logic                    hbus_rst,
  input  hbus_pkg::hbus_cmd_t     cmd_i,
  input  logic                    cmd_empty_i,
  input  logic                    hbus_ready_i,
  input  logic                    hbus_valid_i,
  input  logic                    hbus_busy_i,
  input  logic                    last_i,
  output logic                    cmd_pop_o,
  output logic                    tx_pop_o,
  output logic                    rx_push_o,
  output logic                    cnt_load_o,
  output logic                    cnt_dec_o,
  output logic [`HBUS_ADDR_W-1:0] hbus_adr_o,
  output logic                    hbus_rrq_o,
  output logic                    hbus_wrq_o,
  hbus_shift_if.fsm               shift
);
  import hbus_pkg::*;

  hbus_state_e state;
  logic        take_cmd;

  // A command starts only while the memory is free
  assign take_cmd = (state == IDLE) && !cmd_empty_i && !hbus_busy_i;

  always_comb begin
    cmd_pop_o        = 1'b0;
    tx_pop_o         = 1'b0;
    rx_push_o        = 1'b0;
    cnt_load_o       = 1'b0;
    cnt_dec_o        = 1'b0;
    shift.load_tx    = 1'b0;
    shift.shift_tx   = 1'b0;
    shift.capture_rx = 1'b0;
    shift.clear_rx   = 1'b0;
    case (state)
      IDLE: begin
        if (take_cmd) begin
          cmd_pop_o      = 1'b1;
          cnt_load_o     = 1'b1;
          tx_pop_o       = cmd_i.is_write;
          shift.load_tx  = cmd_i.is_write;
          shift.clear_rx = !cmd_i.is_write;
        end
      end
      WRITE: begin
        cnt_dec_o      = hbus_ready_i;
        shift.shift_tx = hbus_ready_i;
      end
      READ: begin
        cnt_dec_o        = hbus_valid_i;
        shift.capture_rx = hbus_valid_i;
      end
      PUSH: rx_push_o = 1'b1;
      default: ;
    endcase
  end

  always_ff @(posedge clk or posedge hbus_rst) begin
    if (hbus_rst) begin
      state      <= IDLE;
      hbus_rrq_o <= 1'b0;
      hbus_wrq_o <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (take_cmd && cmd_i.is_write) begin
            state      <= WRITE;
            hbus_wrq_o <= 1'b1;
          end else if (take_cmd) begin
            state      <= READ;
            hbus_rrq_o <= 1'b1;
          end
        end
        WRITE: begin
          // Request drops on the edge that takes the last beat
          if (hbus_ready_i && last_i) begin
            state      <= IDLE;
            hbus_wrq_o <= 1'b0;
          end
        end
        READ: begin
          if (hbus_valid_i && last_i) begin
            state      <= PUSH;
            hbus_rrq_o <= 1'b0;
          end
        end
        PUSH:    state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // Address held for the whole transfer
  always_ff @(posedge clk) begin
    if (take_cmd) begin
      hbus_adr_o <= cmd_i.addr;
    end
  end

endmodule

// File: hbus_beat_shifter.sv
`include "hbus_config.svh"

module hbus_beat_shifter (
  input  logic                    clk,
  input  logic                    hbus_rst,
  hbus_shift_if.shifter           shift,
  input  hbus_pkg::hbus_word_u    tx_word_i,
  input  logic [`HBUS_DATA_W-1:0] hbus_dat_i
);
  import hbus_pkg::*;

  localparam int IDX_W = (`HBUS_BEATS > 1) ? $clog2(`HBUS_BEATS) : 1;

  hbus_word_u       tx_q;
  hbus_word_u       rx_q;
  logic [IDX_W-1:0] rx_idx;

  // Transmit side
  // Beat 0 always holds the next beat to send
  always_ff @(posedge clk) begin
    if (shift.load_tx) begin
      tx_q <= tx_word_i;
    end else if (shift.shift_tx) begin
      for (int i = 0; i < `HBUS_BEATS - 1; i++) begin
        tx_q.beat[i] <= tx_q.beat[i+1];
      end
      tx_q.beat[`HBUS_BEATS-1] <= '0;
    end
  end

  assign shift.tx_beat = tx_q.beat[0];

  // Receive side
  // Beats land low half first
  always_ff @(posedge clk) begin
    if (shift.capture_rx) begin
      rx_q.beat[rx_idx] <= hbus_dat_i;
    end
  end

  always_ff @(posedge clk or posedge hbus_rst) begin
    if (hbus_rst) begin
      rx_idx <= '0;
    end else if (shift.clear_rx) begin
      rx_idx <= '0;
    end else if (shift.capture_rx) begin
      rx_idx <= rx_idx + 1'b1;
    end
  end

  assign shift.rx_word = rx_q;

endmodule

// File: hbus_beat_counter.sv
`include "hbus_config.svh"

module hbus_beat_counter (
  input  logic clk,
  input  logic hbus_rst,
  input  logic load_i,
  input  logic dec_i,
  output logic last_o
);

  localparam int CNT_W = $clog2(`HBUS_BEATS + 1);

  // Beats still to move in the current transfer
  logic [CNT_W-1:0] remaining;

  always_ff @(posedge clk or posedge hbus_rst) begin
    if (hbus_rst) begin
      remaining <= '0;
    end else if (load_i) begin
      remaining <= CNT_W'(`HBUS_BEATS);
    end else if (dec_i && (remaining != '0)) begin
      remaining <= remaining - 1'b1;
    end
  end

  // One beat left, so the next accepted beat ends the transfer
  assign last_o = (remaining == CNT_W'(1));

endmodule

// File: hbus_sync_fifo.sv
module hbus_sync_fifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 4
) (
  input  logic             clk,
  input  logic             hbus_rst,
  input  logic             push_i,
  input  logic             pop_i,
  input  logic [WIDTH-1:0] wdata_i,
  output logic [WIDTH-1:0] rdata_o,
  output logic             full_o,
  output logic             empty_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  // Pointer advance with wrap at the last entry
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Overflow and underflow requests are ignored
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  assign full_o  = (count == CNT_W'(DEPTH));
  assign empty_o = (count == '0);

  // Head is visible before it is popped
  assign rdata_o = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= wdata_i;
    end
  end

  always_ff @(posedge clk or posedge hbus_rst) begin
    if (hbus_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: hbus_shift_if.sv
`include "hbus_config.svh"

interface hbus_shift_if;
  import hbus_pkg::*;

  // Controls from the sequencer
  logic load_tx;
  logic shift_tx;
  logic capture_rx;
  logic clear_rx;

  // Data returned by the shifter
  logic [`HBUS_DATA_W-1:0] tx_beat;
  hbus_word_u              rx_word;

  modport fsm (
    output load_tx,
    output shift_tx,
    output capture_rx,
    output clear_rx
  );

  modport shifter (
    input  load_tx,
    input  shift_tx,
    input  capture_rx,
    input  clear_rx,
    output tx_beat,
    output rx_word
  );

endinterface

// File: hbus_pkg.sv
`include "hbus_config.svh"

package hbus_pkg;

  // Entry of the command queue
  typedef struct packed {
    logic                    is_write;
    logic [`HBUS_ADDR_W-1:0] addr;
  } hbus_cmd_t;

  // A user word, seen whole or as bus beats
  // Beat 0 is the low half and goes out first
  typedef union packed {
    logic [`HBUS_WORD_W-1:0]                    word;
    logic [`HBUS_BEATS-1:0][`HBUS_DATA_W-1:0]   beat;
  } hbus_word_u;

  // Bridge sequencer states
  typedef enum logic [1:0] {
    IDLE,
    WRITE,
    READ,
    PUSH
  } hbus_state_e;

endpackage

// File: hbus_config.svh
`ifndef HBUS_CONFIG_SVH
`define HBUS_CONFIG_SVH

// HyperBus native interface widths
`define HBUS_ADDR_W 32
`define HBUS_DATA_W 16

// User word as seen on the queue side
`define HBUS_WORD_W 32

// Beats needed to move one user word
`define HBUS_BEATS (`HBUS_WORD_W / `HBUS_DATA_W)

// Entries per queue
`define HBUS_QDEPTH 4

`endif
